//--- sources.f
rv32i_pkg.sv
rvc_pkg.sv
c_expand_if.sv
c_expand_q0.sv
c_expand_q1.sv
c_expand_q2.sv
c_expand_stage.sv
c_instruction_expander.sv
tb_c_instruction_expander.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_c_instruction_expander
RTL_TOP   ?= c_instruction_expander
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Simulation passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_c_instruction_expander.sv
`timescale 1ns/1ps

module tb_c_instruction_expander;
    import rv32i_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int N_ENC        = 26;
    localparam int N_SIGN       = 13;
    localparam int N_UNSUP      = 10;
    localparam int STREAM_WORDS = 200;
    localparam int MAX_GAP      = 3;
    // reset, every directed beat, worst case streaming and some slack
    localparam int WATCHDOG_CYCLES = 2 + 4 + N_ENC + N_SIGN + N_UNSUP + 2
                                     + STREAM_WORDS * (MAX_GAP + 1) + 100;

    // one per supported instruction, q0 then q1 then q2
    localparam logic [15:0] ENC_WORDS [N_ENC] = '{
        16'h0ffc, 16'h5df4, 16'hdef8,
        16'h0505, 16'h2805, 16'h4529, 16'h6785, 16'h6141, 16'h83c1, 16'h8791,
        16'h9b7d, 16'h8c09, 16'h8d2d, 16'h8f59, 16'h8e7d, 16'ha801, 16'hc511,
        16'he091,
        16'h050a, 16'h50fe, 16'h8082, 16'h852e, 16'h9002, 16'h9782, 16'h952e,
        16'hdf86
    };
    // jumps and branches both ways, then negative addi/li/lui/addi16sp
    localparam logic [15:0] SIGN_WORDS [N_SIGN] = '{
        16'h2805, 16'h3ffd, 16'ha801, 16'hbffd, 16'hb555, 16'hc511, 16'hdffd,
        16'he091, 16'hf07d, 16'h157d, 16'h5541, 16'h77fd, 16'h7171
    };
    localparam logic [15:0] UNSUP_WORDS [N_UNSUP] = '{
        16'h2000, 16'h6000, 16'h8000, 16'ha000, 16'he000,
        16'h2002, 16'h6002, 16'ha002, 16'he002, 16'h9c01  // last is subw space
    };

    logic        clk_i;
    logic        rst_n_i;
    logic        valid_i;
    logic [31:0] inst_i;
    logic        valid_o;
    logic [31:0] inst_o;

    logic        pend_valid;  // valid_i of the beat in flight
    xlen_inst_t  held_exp;    // what inst_o should show after the next edge

    c_instruction_expander u_dut (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .valid_i (valid_i),
        .inst_i  (inst_i),
        .valid_o (valid_o),
        .inst_o  (inst_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not finish in the expected time");
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

    function automatic xlen_inst_t i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic xlen_inst_t r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic xlen_inst_t s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
    endfunction

    function automatic xlen_inst_t b_type(input logic [12:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd0, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic xlen_inst_t j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    // expansion straight from the rv32c tables
    function automatic xlen_inst_t expand_ref(input logic [31:0] w);
        logic [15:0] c;
        logic [4:0]  rd;
        logic [4:0]  rs2;
        logic [4:0]  rdp;
        logic [4:0]  rs2p;
        logic [11:0] simm;
        logic [20:0] joff;
        logic [12:0] boff;
        xlen_inst_t  r;
        c    = w[15:0];
        rd   = c[11:7];
        rs2  = c[6:2];
        rdp  = {2'b01, c[9:7]};
        rs2p = {2'b01, c[4:2]};
        simm = {{6{c[12]}}, c[12], c[6:2]};
        joff = {{9{c[12]}}, c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
        boff = {{4{c[12]}}, c[12], c[6:5], c[2], c[11:10], c[4:3], 1'b0};
        r    = 32'h0000_0013;  // addi x0, x0, 0
        case ({c[1:0], c[15:13]})
            5'b00_000: r = i_type({2'b0, c[10:7], c[12:11], c[5], c[6], 2'b0}, 5'd2, 3'b000,
                                  rs2p, 7'h13);
            5'b00_010: r = i_type({5'b0, c[5], c[12:10], c[6], 2'b0}, rdp, 3'b010, rs2p, 7'h03);
            5'b00_110: r = s_type({5'b0, c[5], c[12:10], c[6], 2'b0}, rs2p, rdp, 3'b010);
            5'b01_000: r = i_type(simm, rd, 3'b000, rd, 7'h13);
            5'b01_001: r = j_type(joff, 5'd1);
            5'b01_010: r = i_type(simm, 5'd0, 3'b000, rd, 7'h13);
            5'b01_011: begin
                if (rd == 5'd2) begin  // addi16sp
                    r = i_type({{2{c[12]}}, c[12], c[4:3], c[5], c[2], c[6], 4'b0}, 5'd2,
                               3'b000, 5'd2, 7'h13);
                end else begin
                    r = {{14{c[12]}}, c[12], c[6:2], rd, 7'h37};
                end
            end
            5'b01_100: begin
                case (c[11:10])
                    2'b00: r = i_type({7'b0, c[6:2]}, rdp, 3'b101, rdp, 7'h13);
                    2'b01: r = i_type({7'b0100000, c[6:2]}, rdp, 3'b101, rdp, 7'h13);
                    2'b10: r = i_type(simm, rdp, 3'b111, rdp, 7'h13);
                    default: begin
                        if (!c[12]) begin
                            case (c[6:5])
                                2'b00:   r = r_type(7'h20, rs2p, rdp, 3'b000, rdp);
                                2'b01:   r = r_type(7'h00, rs2p, rdp, 3'b100, rdp);
                                2'b10:   r = r_type(7'h00, rs2p, rdp, 3'b110, rdp);
                                default: r = r_type(7'h00, rs2p, rdp, 3'b111, rdp);
                            endcase
                        end
                    end
                endcase
            end
            5'b01_101: r = j_type(joff, 5'd0);
            5'b01_110: r = b_type(boff, rdp, 3'b000);
            5'b01_111: r = b_type(boff, rdp, 3'b001);
            5'b10_000: r = i_type({7'b0, rs2}, rd, 3'b001, rd, 7'h13);
            5'b10_010: r = i_type({4'b0, c[3:2], c[12], c[6:4], 2'b0}, 5'd2, 3'b010, rd, 7'h03);
            5'b10_100: begin
                if (!c[12]) begin
                    r = (rs2 == 5'd0) ? i_type(12'd0, rd, 3'b000, 5'd0, 7'h67)
                                      : r_type(7'h00, rs2, 5'd0, 3'b000, rd);
                end else if (rs2 != 5'd0) begin
                    r = r_type(7'h00, rs2, rd, 3'b000, rd);
                end else if (rd == 5'd0) begin
                    r = 32'h0010_0073;  // ebreak
                end else begin
                    r = i_type(12'd0, rd, 3'b000, 5'd1, 7'h67);
                end
            end
            5'b10_110: r = s_type({4'b0, c[8:7], c[12:9], 2'b0}, rs2, 5'd2, 3'b010);
            default: r = 32'h0000_0013;
        endcase
        if (c[1:0] == 2'b11) begin
            r = w;  // full-length words go through as they are
        end
        return r;
    endfunction

    task automatic check_inst(input xlen_inst_t act, input xlen_inst_t exp);
        if (act !== exp) begin
            $display("Error: inst_o expected 0x%08h actual 0x%08h", exp, act);
            $display("Simulation failed");
            $fatal(1, "inst_o mismatch");
        end
    endtask

    task automatic check_valid(input logic act, input logic exp);
        if (act !== exp) begin
            $display("Error: valid_o expected 0x%0h actual 0x%0h", exp, act);
            $display("Simulation failed");
            $fatal(1, "valid_o mismatch");
        end
    endtask

    // check the beat in flight, then drive the next one
    task automatic step_cycle(input logic v, input logic [31:0] w);
        @(posedge clk_i);
        #2;
        check_valid(valid_o, pend_valid);
        check_inst(inst_o, held_exp);
        valid_i    = v;
        inst_i     = w;
        pend_valid = v;
        if (v) begin
            held_exp = expand_ref(w);
        end
    endtask

    task automatic send_compressed(input logic [15:0] c);
        logic [31:0] r;
        r = $urandom;
        step_cycle(1'b1, {r[31:16], c});  // upper half must not matter
    endtask

    task automatic test_reset();
        logic [31:0] r;
        repeat (4) begin
            r = $urandom;
            step_cycle(1'b0, r);
        end
    endtask

    task automatic test_encodings();
        for (int i = 0; i < N_ENC; i++) send_compressed(ENC_WORDS[i]);
    endtask

    task automatic test_immediates();
        for (int i = 0; i < N_SIGN; i++) send_compressed(SIGN_WORDS[i]);
    endtask

    task automatic test_unsupported();
        for (int i = 0; i < N_UNSUP; i++) send_compressed(UNSUP_WORDS[i]);
        step_cycle(1'b1, 32'h0010_0093);
        step_cycle(1'b1, 32'hdead_beef);
    endtask

    task automatic test_streaming();
        int          gap;
        logic [31:0] w;
        for (int i = 0; i < STREAM_WORDS; i++) begin
            gap = int'($urandom % (MAX_GAP + 1));
            repeat (gap) begin
                w = $urandom;
                step_cycle(1'b0, w);  // junk on inst_i while idle
            end
            w = $urandom;
            step_cycle(1'b1, w);
        end
    endtask

    initial begin
        void'($urandom(32'h39ef_1d47));
        rst_n_i    = 1'b0;
        valid_i    = 1'b0;
        inst_i     = '0;
        pend_valid = 1'b0;
        held_exp   = '0;
        repeat (2) @(posedge clk_i);
        #2;
        rst_n_i = 1'b1;
        test_reset();
        test_encodings();
        test_immediates();
        test_unsupported();
        test_streaming();
        step_cycle(1'b0, 32'h0);  // last beat still in flight
        $display("Simulation passed");
        $finish;
    end

endmodule

//--- c_instruction_expander.sv
`timescale 1ns/1ps

module c_instruction_expander (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        valid_i,
    input  logic [31:0] inst_i,
    output logic        valid_o,
    output logic [31:0] inst_o
);

    c_expand_if u_if ();

    c_expand_stage u_stage (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .valid_i (valid_i),
        .inst_i  (inst_i),
        .valid_o (valid_o),
        .inst_o  (inst_o),
        .ifc     (u_if.sel)
    );

    // one combinational expander per quadrant
    c_expand_q0 u_q0 (.ifc(u_if.q0));
    c_expand_q1 u_q1 (.ifc(u_if.q1));
    c_expand_q2 u_q2 (.ifc(u_if.q2));

endmodule

//--- c_expand_stage.sv
`timescale 1ns/1ps

module c_expand_stage (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  valid_i,
    input  rv32i_pkg::xlen_inst_t inst_i,
    output logic                  valid_o,
    output rv32i_pkg::xlen_inst_t inst_o,
    c_expand_if.sel               ifc
);
    import rv32i_pkg::*;
    import rvc_pkg::*;

    xlen_inst_t inst_nxt;

    assign ifc.cinst = inst_i[15:0];  // expanders only see the low half

    always_comb begin
        case (ifc.cinst.full.quad)
            QUAD_0:    inst_nxt = ifc.q0_word;
            QUAD_1:    inst_nxt = ifc.q1_word;
            QUAD_2:    inst_nxt = ifc.q2_word;
            QUAD_FULL: inst_nxt = inst_i;  // already 32-bit
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
            inst_o  <= '0;
        end else begin
            valid_o <= valid_i;
            if (valid_i) begin
                inst_o <= inst_nxt;  // hold between beats
            end
        end
    end

    // quadrant 0 only yields addi, lw or sw
    a_q0_opcode: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (valid_i && (ifc.cinst.full.quad == QUAD_0))
            |-> ((ifc.q0_word[6:0] == OPC_OP_IMM) || (ifc.q0_word[6:0] == OPC_LOAD)
                 || (ifc.q0_word[6:0] == OPC_STORE))
    );

    // every expander must produce a full-length encoding
    a_full_length_out: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        valid_o |-> (inst_o[1:0] == QUAD_FULL)
    );

endmodule

//--- c_expand_q2.sv
`timescale 1ns/1ps

module c_expand_q2 (
    c_expand_if.q2 ifc
);
    import rv32i_pkg::*;
    import rvc_pkg::*;

    logic [15:0] cw;
    reg_idx_t    rd;        // rd/rs1
    reg_idx_t    rs2;
    logic [11:0] lwsp_imm;  // uimm[5] bit 12, uimm[4:2|7:6] bits 6:2
    logic [11:0] swsp_imm;  // uimm[5:2|7:6] bits 12:7

    assign cw  = ifc.cinst;
    assign rd  = ifc.cinst.full.rd_rs1;
    assign rs2 = ifc.cinst.full.rs2;

    assign lwsp_imm = {4'b0, cw[3:2], cw[12], cw[6:4], 2'b00};
    assign swsp_imm = {4'b0, cw[8:7], cw[12:9], 2'b00};

    always_comb begin
        case (ifc.cinst.full.funct3)
            C2_SLLI: ifc.q2_word = {7'b0, rs2, rd, F3_SLL, rd, OPC_OP_IMM};
            C2_LWSP: ifc.q2_word = {lwsp_imm, REG_SP, F3_W, rd, OPC_LOAD};
            C2_SWSP: begin
                ifc.q2_word = {swsp_imm[11:5], rs2, REG_SP, F3_W, swsp_imm[4:0], OPC_STORE};
            end
            C2_JR_MV: begin
                if (!ifc.cinst.full.b12) begin
                    if (rs2 == REG_ZERO) begin
                        ifc.q2_word = {12'b0, rd, F3_ADD, REG_ZERO, OPC_JALR};  // c.jr
                    end else begin
                        ifc.q2_word = {7'b0, rs2, REG_ZERO, F3_ADD, rd, OPC_OP};  // c.mv
                    end
                end else if (rs2 != REG_ZERO) begin
                    ifc.q2_word = {7'b0, rs2, rd, F3_ADD, rd, OPC_OP};  // c.add
                end else if (rd == REG_ZERO) begin
                    ifc.q2_word = INST_EBREAK;
                end else begin
                    // c.jalr links through ra
                    ifc.q2_word = {12'b0, rd, F3_ADD, REG_RA, OPC_JALR};
                end
            end
            default: begin
                ifc.q2_word = INST_NOP;
            end
        endcase
    end

endmodule

//--- c_expand_q1.sv
`timescale 1ns/1ps

module c_expand_q1 (
    c_expand_if.q1 ifc
);
    import rv32i_pkg::*;
    import rvc_pkg::*;

    logic [15:0] cw;
    reg_idx_t    rd;      // full rd/rs1 field
    reg_idx_t    rd_p;    // rd'/rs1' of arith and branch forms
    reg_idx_t    rs2_p;
    logic [11:0] imm6;    // sign-extended imm[5:0]
    logic [11:0] sp_imm;  // c.addi16sp nzimm
    logic [11:0] j_off;   // c.j / c.jal offset
    logic [8:0]  b_off;   // c.beqz / c.bnez offset

    assign cw    = ifc.cinst;
    assign rd    = ifc.cinst.full.rd_rs1;
    assign rd_p  = {PRIME_BASE, ifc.cinst.prime.rs1_p};
    assign rs2_p = {PRIME_BASE, ifc.cinst.prime.rs2_p};

    assign imm6   = {{7{cw[12]}}, cw[6:2]};
    assign sp_imm = {{3{cw[12]}}, cw[4:3], cw[5], cw[2], cw[6], 4'b0000};

    // offset[11|4|9:8|10|6|7|3:1|5]
    assign j_off = {cw[12], cw[8], cw[10:9], cw[6], cw[7], cw[2], cw[11], cw[5:3], 1'b0};
    // offset[8|4:3] and [7:6|2:1|5]
    assign b_off = {cw[12], cw[6:5], cw[2], cw[11:10], cw[4:3], 1'b0};

    always_comb begin
        ifc.q1_word = INST_NOP;
        case (ifc.cinst.full.funct3)
            C1_ADDI: ifc.q1_word = {imm6, rd, F3_ADD, rd, OPC_OP_IMM};
            C1_LI:   ifc.q1_word = {imm6, REG_ZERO, F3_ADD, rd, OPC_OP_IMM};
            C1_JAL: begin
                ifc.q1_word = {j_off[11], j_off[10:1], j_off[11], {8{j_off[11]}},
                               REG_RA, OPC_JAL};
            end
            C1_J: begin
                ifc.q1_word = {j_off[11], j_off[10:1], j_off[11], {8{j_off[11]}},
                               REG_ZERO, OPC_JAL};
            end
            C1_LUI: begin
                if (rd == REG_SP) begin  // c.addi16sp
                    ifc.q1_word = {sp_imm, REG_SP, F3_ADD, REG_SP, OPC_OP_IMM};
                end else begin
                    ifc.q1_word = {{15{cw[12]}}, cw[6:2], rd, OPC_LUI};
                end
            end
            C1_ARITH: begin
                // shamt[5] (bit 12) is ignored on rv32
                case (ifc.cinst.prime.sub_op)
                    SUB_SRLI: ifc.q1_word = {7'b0, cw[6:2], rd_p, F3_SR, rd_p, OPC_OP_IMM};
                    SUB_SRAI: ifc.q1_word = {F7_ALT, cw[6:2], rd_p, F3_SR, rd_p, OPC_OP_IMM};
                    SUB_ANDI: ifc.q1_word = {imm6, rd_p, F3_AND, rd_p, OPC_OP_IMM};
                    SUB_REG: begin
                        // bit 12 set is subw/addw space, not rv32
                        if (!ifc.cinst.prime.b12) begin
                            case (ifc.cinst.prime.funct2)
                                F2_SUB: ifc.q1_word = {F7_ALT, rs2_p, rd_p, F3_ADD, rd_p, OPC_OP};
                                F2_XOR: ifc.q1_word = {7'b0, rs2_p, rd_p, F3_XOR, rd_p, OPC_OP};
                                F2_OR:  ifc.q1_word = {7'b0, rs2_p, rd_p, F3_OR, rd_p, OPC_OP};
                                F2_AND: ifc.q1_word = {7'b0, rs2_p, rd_p, F3_AND, rd_p, OPC_OP};
                            endcase
                        end
                    end
                endcase
            end
            C1_BEQZ: begin
                ifc.q1_word = {b_off[8], {2{b_off[8]}}, b_off[8:5], REG_ZERO, rd_p,
                               F3_BEQ, b_off[4:1], b_off[8], OPC_BRANCH};
            end
            C1_BNEZ: begin
                ifc.q1_word = {b_off[8], {2{b_off[8]}}, b_off[8:5], REG_ZERO, rd_p,
                               F3_BNE, b_off[4:1], b_off[8], OPC_BRANCH};
            end
        endcase
    end

endmodule

//--- c_expand_q0.sv
`timescale 1ns/1ps

module c_expand_q0 (
    c_expand_if.q0 ifc
);
    import rv32i_pkg::*;
    import rvc_pkg::*;

    logic [15:0] cw;      // raw bits for immediate scatter
    reg_idx_t    rd_p;    // rd' of c.lw / addi4spn, rs2' of c.sw
    reg_idx_t    rs1_p;
    logic [11:0] spn_imm;
    logic [11:0] ls_imm;  // c.lw / c.sw word offset

    assign cw    = ifc.cinst;
    assign rd_p  = {PRIME_BASE, ifc.cinst.prime.rs2_p};
    assign rs1_p = {PRIME_BASE, ifc.cinst.prime.rs1_p};

    // nzuimm[5:4|9:6|2|3] in bits 12:5
    assign spn_imm = {2'b00, cw[10:7], cw[12:11], cw[5], cw[6], 2'b00};
    assign ls_imm  = {5'b0, cw[5], cw[12:10], cw[6], 2'b00};

    always_comb begin
        case (ifc.cinst.prime.funct3)
            C0_ADDI4SPN: begin
                ifc.q0_word = {spn_imm, REG_SP, F3_ADD, rd_p, OPC_OP_IMM};
            end
            C0_LW: begin
                ifc.q0_word = {ls_imm, rs1_p, F3_W, rd_p, OPC_LOAD};
            end
            C0_SW: begin
                // s-type split of the same offset
                ifc.q0_word = {ls_imm[11:5], rd_p, rs1_p, F3_W, ls_imm[4:0], OPC_STORE};
            end
            default: begin
                ifc.q0_word = INST_NOP;
            end
        endcase
    end

endmodule

//--- c_expand_if.sv
`timescale 1ns/1ps

interface c_expand_if;
    import rv32i_pkg::*;
    import rvc_pkg::*;

    rvc_inst_t  cinst;    // low half of the incoming word
    xlen_inst_t q0_word;
    xlen_inst_t q1_word;
    xlen_inst_t q2_word;

    modport sel (
        output cinst,
        input  q0_word, q1_word, q2_word
    );

    modport q0 (input cinst, output q0_word);
    modport q1 (input cinst, output q1_word);
    modport q2 (input cinst, output q2_word);

endinterface

//--- rvc_pkg.sv
package rvc_pkg;

    // quadrant field, bits 1:0 of every instruction
    localparam logic [1:0] QUAD_0    = 2'b00;
    localparam logic [1:0] QUAD_1    = 2'b01;
    localparam logic [1:0] QUAD_2    = 2'b10;
    localparam logic [1:0] QUAD_FULL = 2'b11;  // not compressed

    // quadrant 0 funct3
    localparam logic [2:0] C0_ADDI4SPN = 3'b000;
    localparam logic [2:0] C0_LW       = 3'b010;
    localparam logic [2:0] C0_SW       = 3'b110;

    // quadrant 1 funct3
    localparam logic [2:0] C1_ADDI  = 3'b000;
    localparam logic [2:0] C1_JAL   = 3'b001;
    localparam logic [2:0] C1_LI    = 3'b010;
    localparam logic [2:0] C1_LUI   = 3'b011;  // shared with c.addi16sp
    localparam logic [2:0] C1_ARITH = 3'b100;
    localparam logic [2:0] C1_J     = 3'b101;
    localparam logic [2:0] C1_BEQZ  = 3'b110;
    localparam logic [2:0] C1_BNEZ  = 3'b111;

    // quadrant 2 funct3
    localparam logic [2:0] C2_SLLI  = 3'b000;
    localparam logic [2:0] C2_LWSP  = 3'b010;
    localparam logic [2:0] C2_JR_MV = 3'b100;  // jr/mv/ebreak/jalr/add group
    localparam logic [2:0] C2_SWSP  = 3'b110;

    // quadrant 1 arithmetic sub-op, bits 11:10
    localparam logic [1:0] SUB_SRLI = 2'b00;
    localparam logic [1:0] SUB_SRAI = 2'b01;
    localparam logic [1:0] SUB_ANDI = 2'b10;
    localparam logic [1:0] SUB_REG  = 2'b11;

    // register-register funct2, bits 6:5
    localparam logic [1:0] F2_SUB = 2'b00;
    localparam logic [1:0] F2_XOR = 2'b01;
    localparam logic [1:0] F2_OR  = 2'b10;
    localparam logic [1:0] F2_AND = 2'b11;

    // x8..x15 prefix for 3-bit register fields
    localparam logic [1:0] PRIME_BASE = 2'b01;

    typedef union packed {
        struct packed {
            logic [2:0] funct3;
            logic       b12;
            logic [4:0] rd_rs1;
            logic [4:0] rs2;
            logic [1:0] quad;
        } full;
        struct packed {
            logic [2:0] funct3;
            logic       b12;
            logic [1:0] sub_op;
            logic [2:0] rs1_p;   // rd'/rs1'
            logic [1:0] funct2;
            logic [2:0] rs2_p;   // rs2'/rd'
            logic [1:0] quad;
        } prime;
    } rvc_inst_t;

endpackage

//--- rv32i_pkg.sv
package rv32i_pkg;

    typedef logic [31:0] xlen_inst_t;
    typedef logic [4:0]  reg_idx_t;

    // major opcodes
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // funct3 values
    localparam logic [2:0] F3_ADD = 3'b000;  // also jalr
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SR  = 3'b101;  // srli and srai
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [2:0] F3_W   = 3'b010;  // word load/store
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;

    // bit 30 set, selects sub and srai
    localparam logic [6:0] F7_ALT = 7'b0100000;

    localparam reg_idx_t REG_ZERO = 5'd0;
    localparam reg_idx_t REG_RA   = 5'd1;
    localparam reg_idx_t REG_SP   = 5'd2;

    localparam xlen_inst_t INST_NOP    = 32'h0000_0013;  // addi x0, x0, 0
    localparam xlen_inst_t INST_EBREAK = 32'h0010_0073;

endpackage
